// ==== source/gpu_cfg.svh ====
//****************************************
// Fixed constants only, nothing here is meant to vary
// Frame size must stay 16x16 to match the 8 bit word address
//****************************************
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

// Local bus register map
`define GPU_CONTROL_ADDR    8'h00
`define GPU_STATUS_ADDR     8'h04
`define GPU_JOB_ACTION_ADDR 8'h08
`define GPU_JOB_X0_ADDR     8'h0C
`define GPU_JOB_Y0_ADDR     8'h10
`define GPU_JOB_X1_ADDR     8'h14
`define GPU_JOB_Y1_ADDR     8'h18
`define GPU_JOB_COLOR_ADDR  8'h1C
`define GPU_PXL_ADDR_ADDR   8'h20
`define GPU_PXL_DATA_ADDR   8'h24

// Frame geometry
`define GPU_FRAME_W 16
`define GPU_FRAME_H 16

// Field widths
`define GPU_COORD_W   4
`define GPU_COLOR_W   8
`define GPU_FB_ADDR_W 8
`define GPU_LB_ADDR_W 8
`define GPU_LB_DATA_W 32

// Returned for unmapped register reads
`define GPU_BAD_ADDR_DATA 32'hdeadbabe

`endif

// ==== source/gpu_pkg.sv ====
//****************************************
// Shared types of the drawing core
//****************************************
`include "gpu_cfg.svh"

package gpu_pkg;

  // Pixel X or Y position
  typedef logic [`GPU_COORD_W-1:0] coord_t;

  // Pixel colour, one byte per pixel
  typedef logic [`GPU_COLOR_W-1:0] color_t;

  // Frame word address, Y in upper nibble, X in lower
  typedef logic [`GPU_FB_ADDR_W-1:0] fb_addr_t;

  // Host local bus
  typedef logic [`GPU_LB_ADDR_W-1:0] lb_addr_t;
  typedef logic [`GPU_LB_DATA_W-1:0] lb_data_t;

  // Job action codes as written to JOB_ACTION
  typedef enum logic [1:0]
  {
    DRAW  = 2'd0,
    CLEAR = 2'd1
  } action_t;

endpackage

// ==== source/gpu_regs.sv ====
//****************************************
// Host must not strobe again until a PXL_DATA read returns
// Job start needs CONTROL enable set at the JOB_ACTION write
//****************************************
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_regs
(
  input  logic              cr_intf,
  input  logic              rst_n,
  // Host local bus
  input  gpu_pkg::lb_addr_t addr,
  input  logic              wr_en,
  input  gpu_pkg::lb_data_t wr_data,
  input  logic              rd_en,
  output logic              wr_valid,
  output logic              rd_valid,
  output gpu_pkg::lb_data_t rd_data,
  // Job launch towards the engine
  input  logic              busy,
  output logic              job_start,
  output gpu_pkg::coord_t   x0,
  output gpu_pkg::coord_t   y0,
  output gpu_pkg::coord_t   x1,
  output gpu_pkg::coord_t   y1,
  output gpu_pkg::color_t   color,
  // Wishbone master 0, pixel readback
  output logic              m0_cyc,
  output logic              m0_stb,
  output logic              m0_we,
  output gpu_pkg::fb_addr_t m0_adr,
  output gpu_pkg::color_t   m0_dat_w,
  input  logic              m0_ack,
  input  gpu_pkg::color_t   m0_dat_r
);

  import gpu_pkg::*;

  logic     enable;
  action_t  action;
  coord_t   job_x0;
  coord_t   job_y0;
  coord_t   job_x1;
  coord_t   job_y1;
  color_t   job_color;
  fb_addr_t pxl_addr;
  // Pixel read in flight on the memory bus
  logic     pxl_pend;

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      enable    <= 1'b0;
      action    <= DRAW;
      job_x0    <= '0;
      job_y0    <= '0;
      job_x1    <= '0;
      job_y1    <= '0;
      job_color <= '0;
      pxl_addr  <= '0;
      pxl_pend  <= 1'b0;
      job_start <= 1'b0;
      wr_valid  <= 1'b0;
      rd_valid  <= 1'b0;
      rd_data   <= '0;
    end
    else
    begin
      // Register writes
      if (wr_en)
      begin
        case (addr)
          `GPU_CONTROL_ADDR:    enable    <= wr_data[0];
          `GPU_JOB_ACTION_ADDR: action    <= action_t'(wr_data[1:0]);
          `GPU_JOB_X0_ADDR:     job_x0    <= wr_data[`GPU_COORD_W-1:0];
          `GPU_JOB_Y0_ADDR:     job_y0    <= wr_data[`GPU_COORD_W-1:0];
          `GPU_JOB_X1_ADDR:     job_x1    <= wr_data[`GPU_COORD_W-1:0];
          `GPU_JOB_Y1_ADDR:     job_y1    <= wr_data[`GPU_COORD_W-1:0];
          `GPU_JOB_COLOR_ADDR:  job_color <= wr_data[`GPU_COLOR_W-1:0];
          `GPU_PXL_ADDR_ADDR:   pxl_addr  <= wr_data[`GPU_FB_ADDR_W-1:0];
          default:              ;
        endcase
      end
      wr_valid <= wr_en;

      // Launch one cycle after the JOB_ACTION write
      job_start <= wr_en && (addr == `GPU_JOB_ACTION_ADDR) && enable;

      // Register reads answer next cycle, PXL_DATA goes to the bus
      if (rd_en)
      begin
        case (addr)
          `GPU_CONTROL_ADDR:    rd_data <= lb_data_t'(enable);
          `GPU_STATUS_ADDR:     rd_data <= lb_data_t'(busy);
          `GPU_JOB_ACTION_ADDR: rd_data <= lb_data_t'(action);
          `GPU_JOB_X0_ADDR:     rd_data <= lb_data_t'(job_x0);
          `GPU_JOB_Y0_ADDR:     rd_data <= lb_data_t'(job_y0);
          `GPU_JOB_X1_ADDR:     rd_data <= lb_data_t'(job_x1);
          `GPU_JOB_Y1_ADDR:     rd_data <= lb_data_t'(job_y1);
          `GPU_JOB_COLOR_ADDR:  rd_data <= lb_data_t'(job_color);
          `GPU_PXL_ADDR_ADDR:   rd_data <= lb_data_t'(pxl_addr);
          `GPU_PXL_DATA_ADDR:   pxl_pend <= 1'b1;
          default:              rd_data <= `GPU_BAD_ADDR_DATA;
        endcase
      end

      // Pixel returns with the ack, drop cyc the cycle after
      if (pxl_pend && m0_ack)
      begin
        pxl_pend <= 1'b0;
        rd_data  <= lb_data_t'(m0_dat_r);
      end

      rd_valid <= (rd_en && (addr != `GPU_PXL_DATA_ADDR)) || (pxl_pend && m0_ack);
    end
  end

  // CLEAR covers the whole frame
  assign x0    = (action == CLEAR) ? coord_t'(0) : job_x0;
  assign y0    = (action == CLEAR) ? coord_t'(0) : job_y0;
  assign x1    = (action == CLEAR) ? coord_t'(`GPU_FRAME_W-1) : job_x1;
  assign y1    = (action == CLEAR) ? coord_t'(`GPU_FRAME_H-1) : job_y1;
  assign color = job_color;

  // Read only master
  assign m0_cyc   = pxl_pend;
  assign m0_stb   = pxl_pend;
  assign m0_we    = 1'b0;
  assign m0_adr   = pxl_addr;
  assign m0_dat_w = '0;

endmodule

// ==== source/gpu_rect_engine.sv ====
//****************************************
// Holds the bus for a whole job, 3 cycles per pixel when granted
// Start pulses during a job are dropped
//****************************************
`timescale 1ns/1ps

module gpu_rect_engine
(
  input  logic              cr_intf,
  input  logic              rst_n,
  // Job from the register block
  input  logic              job_start,
  input  gpu_pkg::coord_t   x0,
  input  gpu_pkg::coord_t   y0,
  input  gpu_pkg::coord_t   x1,
  input  gpu_pkg::coord_t   y1,
  input  gpu_pkg::color_t   color,
  output logic              busy,
  // Wishbone master 1, pixel writes
  output logic              m1_cyc,
  output logic              m1_stb,
  output logic              m1_we,
  output gpu_pkg::fb_addr_t m1_adr,
  output gpu_pkg::color_t   m1_dat_w,
  input  logic              m1_ack
);

  import gpu_pkg::*;

  typedef enum logic [1:0]
  {
    IDLE,
    WRITE,
    NEXT
  } state_t;

  state_t state;
  // Ordered corners and walk position
  coord_t x_min;
  coord_t x_max;
  coord_t y_min;
  coord_t y_max;
  coord_t cur_x;
  coord_t cur_y;
  color_t fill;

  wire last_pxl = (cur_x == x_max) && (cur_y == y_max);

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
    end
    else
    begin
      case (state)
        IDLE:    if (job_start) state <= WRITE;
        // Last ack ends the job
        WRITE:   if (m1_ack) state <= last_pxl ? IDLE : NEXT;
        NEXT:    state <= WRITE;
        default: state <= IDLE;
      endcase
    end
  end

  // Corner ordering and raster walk
  always_ff @(posedge cr_intf)
  begin
    if ((state == IDLE) && job_start)
    begin
      x_min <= (x0 < x1) ? x0 : x1;
      x_max <= (x0 < x1) ? x1 : x0;
      y_min <= (y0 < y1) ? y0 : y1;
      y_max <= (y0 < y1) ? y1 : y0;
      cur_x <= (x0 < x1) ? x0 : x1;
      cur_y <= (y0 < y1) ? y0 : y1;
      fill  <= color;
    end
    else if ((state == WRITE) && m1_ack && !last_pxl)
    begin
      // Row by row, left to right
      if (cur_x == x_max)
      begin
        cur_x <= x_min;
        cur_y <= cur_y + 1'b1;
      end
      else
      begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  assign busy     = (state != IDLE);
  assign m1_cyc   = (state != IDLE);
  assign m1_stb   = (state == WRITE);
  assign m1_we    = (state == WRITE);
  assign m1_adr   = {cur_y, cur_x};
  assign m1_dat_w = fill;

endmodule

// ==== source/gpu_bus_arbiter.sv ====
//****************************************
// Fixed priority to m0, grant held while owner keeps cyc
//****************************************
`timescale 1ns/1ps

module gpu_bus_arbiter
(
  input  logic              cr_intf,
  input  logic              rst_n,
  // Master 0, register block
  input  logic              m0_cyc,
  input  logic              m0_stb,
  input  logic              m0_we,
  input  gpu_pkg::fb_addr_t m0_adr,
  input  gpu_pkg::color_t   m0_dat_w,
  output logic              m0_ack,
  output gpu_pkg::color_t   m0_dat_r,
  // Master 1, rectangle engine
  input  logic              m1_cyc,
  input  logic              m1_stb,
  input  logic              m1_we,
  input  gpu_pkg::fb_addr_t m1_adr,
  input  gpu_pkg::color_t   m1_dat_w,
  output logic              m1_ack,
  // Slave side, frame memory
  output logic              s_cyc,
  output logic              s_stb,
  output logic              s_we,
  output gpu_pkg::fb_addr_t s_adr,
  output gpu_pkg::color_t   s_dat_w,
  input  logic              s_ack,
  input  gpu_pkg::color_t   s_dat_r
);

  // High when m1 owns the bus
  logic grant;

  wire owner_cyc = grant ? m1_cyc : m0_cyc;

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
      grant <= 1'b0;
    // Re-arbitrate only once the owner lets go
    else if (!owner_cyc)
      grant <= !m0_cyc && m1_cyc;
  end

  assign s_cyc   = owner_cyc;
  assign s_stb   = grant ? m1_stb   : m0_stb;
  assign s_we    = grant ? m1_we    : m0_we;
  assign s_adr   = grant ? m1_adr   : m0_adr;
  assign s_dat_w = grant ? m1_dat_w : m0_dat_w;

  // Waiting master sees no ack
  assign m0_ack   = s_ack && !grant;
  assign m1_ack   = s_ack && grant;
  assign m0_dat_r = s_dat_r;

endmodule

// ==== source/gpu_frame_mem.sv ====
//****************************************
// 256x8 pixel store, whole array cleared at reset
// Master must drop stb the cycle after ack
//****************************************
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_frame_mem
(
  input  logic              cr_intf,
  input  logic              rst_n,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  gpu_pkg::fb_addr_t adr,
  input  gpu_pkg::color_t   dat_w,
  output logic              ack,
  output gpu_pkg::color_t   dat_r
);

  import gpu_pkg::*;

  color_t mem [`GPU_FRAME_W*`GPU_FRAME_H];

  // New request this cycle, ack still low
  wire req = cyc && stb && !ack;

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack <= 1'b0;
      for (int i = 0; i < `GPU_FRAME_W*`GPU_FRAME_H; i++)
        mem[i] <= '0;
    end
    else
    begin
      // Single cycle ack, falls with stb
      ack <= req;
      if (req && we)
        mem[adr] <= dat_w;
    end
  end

  always_ff @(posedge cr_intf)
  begin
    if (req)
      dat_r <= mem[adr];
  end

endmodule

// ==== source/gpu_core.sv ====
//****************************************
// Drawing core top, host local bus only
//****************************************
`timescale 1ns/1ps

module gpu_core
(
  input  logic              cr_intf,
  input  logic              rst_n,
  input  gpu_pkg::lb_addr_t addr,
  input  logic              wr_en,
  input  gpu_pkg::lb_data_t wr_data,
  input  logic              rd_en,
  output logic              wr_valid,
  output logic              rd_valid,
  output gpu_pkg::lb_data_t rd_data
);

  import gpu_pkg::*;

  // Job launch
  logic     busy;
  logic     job_start;
  coord_t   job_x0;
  coord_t   job_y0;
  coord_t   job_x1;
  coord_t   job_y1;
  color_t   job_color;

  // Master 0, pixel readback
  logic     m0_cyc;
  logic     m0_stb;
  logic     m0_we;
  fb_addr_t m0_adr;
  color_t   m0_dat_w;
  logic     m0_ack;
  color_t   m0_dat_r;

  // Master 1, engine writes
  logic     m1_cyc;
  logic     m1_stb;
  logic     m1_we;
  fb_addr_t m1_adr;
  color_t   m1_dat_w;
  logic     m1_ack;

  // Arbiter to memory
  logic     s_cyc;
  logic     s_stb;
  logic     s_we;
  fb_addr_t s_adr;
  color_t   s_dat_w;
  logic     s_ack;
  color_t   s_dat_r;

  gpu_regs gpu_regs_inst
  (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .addr      (addr),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .wr_valid  (wr_valid),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .busy      (busy),
    .job_start (job_start),
    .x0        (job_x0),
    .y0        (job_y0),
    .x1        (job_x1),
    .y1        (job_y1),
    .color     (job_color),
    .m0_cyc    (m0_cyc),
    .m0_stb    (m0_stb),
    .m0_we     (m0_we),
    .m0_adr    (m0_adr),
    .m0_dat_w  (m0_dat_w),
    .m0_ack    (m0_ack),
    .m0_dat_r  (m0_dat_r)
  );

  gpu_rect_engine gpu_rect_engine_inst
  (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .job_start (job_start),
    .x0        (job_x0),
    .y0        (job_y0),
    .x1        (job_x1),
    .y1        (job_y1),
    .color     (job_color),
    .busy      (busy),
    .m1_cyc    (m1_cyc),
    .m1_stb    (m1_stb),
    .m1_we     (m1_we),
    .m1_adr    (m1_adr),
    .m1_dat_w  (m1_dat_w),
    .m1_ack    (m1_ack)
  );

  gpu_bus_arbiter gpu_bus_arbiter_inst
  (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .m0_cyc    (m0_cyc),
    .m0_stb    (m0_stb),
    .m0_we     (m0_we),
    .m0_adr    (m0_adr),
    .m0_dat_w  (m0_dat_w),
    .m0_ack    (m0_ack),
    .m0_dat_r  (m0_dat_r),
    .m1_cyc    (m1_cyc),
    .m1_stb    (m1_stb),
    .m1_we     (m1_we),
    .m1_adr    (m1_adr),
    .m1_dat_w  (m1_dat_w),
    .m1_ack    (m1_ack),
    .s_cyc     (s_cyc),
    .s_stb     (s_stb),
    .s_we      (s_we),
    .s_adr     (s_adr),
    .s_dat_w   (s_dat_w),
    .s_ack     (s_ack),
    .s_dat_r   (s_dat_r)
  );

  gpu_frame_mem gpu_frame_mem_inst
  (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .cyc       (s_cyc),
    .stb       (s_stb),
    .we        (s_we),
    .adr       (s_adr),
    .dat_w     (s_dat_w),
    .ack       (s_ack),
    .dat_r     (s_dat_r)
  );

endmodule

// ==== dv/gpu_checker.sv ====
//****************************************
// Host bus monitor with a model frame, one strobe per cycle
// STATUS must read 1 two and three cycles after a launch write
// and may read 1 after that only until its first 0
//****************************************
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module gpu_checker
(
  input  logic              cr_intf,
  input  logic              rst_n,
  input  gpu_pkg::lb_addr_t addr,
  input  logic              wr_en,
  input  gpu_pkg::lb_data_t wr_data,
  input  logic              rd_en,
  input  logic              wr_valid,
  input  logic              rd_valid,
  input  gpu_pkg::lb_data_t rd_data,
  output int                error_count,
  output int                check_count
);

  import gpu_pkg::*;

  // A pixel read can sit behind a full frame job
  localparam int PXL_WAIT_LIMIT = 1000;
  localparam int FRAME_PIXELS = `GPU_FRAME_W * `GPU_FRAME_H;
  // job_start one cycle after the write, busy the cycle after that
  localparam int BUSY_FIRST_AGE = 2;
  // Even a one pixel job stays busy until its ack
  localparam int BUSY_LAST_AGE = 3;

  // Mirror of the host visible registers
  logic     enable;
  action_t  action;
  coord_t   job_x0;
  coord_t   job_y0;
  coord_t   job_x1;
  coord_t   job_y1;
  color_t   job_color;
  fb_addr_t pxl_addr;

  // Model frame, Y in upper nibble of the index
  color_t   model [FRAME_PIXELS];
  logic     job_running;
  // Cycles since the last launch write
  int       launch_age;

  // Responses owed by the DUT
  logic     wr_expect;
  logic     rd_expect;
  logic     status_any;
  logic     pxl_wait;
  int       pxl_cycles;
  lb_addr_t exp_addr;
  lb_data_t exp_data;

  // New value of one pixel after a job
  function automatic color_t expected_pixel
  (
    input action_t act,
    input coord_t  ax,
    input coord_t  ay,
    input coord_t  bx,
    input coord_t  by,
    input color_t  fill,
    input int      pos,
    input color_t  old
  );
    int px;
    int py;
    int lo_x;
    int hi_x;
    int lo_y;
    int hi_y;
    px = pos % `GPU_FRAME_W;
    py = pos / `GPU_FRAME_W;
    // CLEAR ignores the corners
    if (act == CLEAR)
      return fill;
    // Corners may come in either order
    lo_x = (ax < bx) ? int'(ax) : int'(bx);
    hi_x = (ax < bx) ? int'(bx) : int'(ax);
    lo_y = (ay < by) ? int'(ay) : int'(by);
    hi_y = (ay < by) ? int'(by) : int'(ay);
    if (px >= lo_x && px <= hi_x && py >= lo_y && py <= hi_y)
      return fill;
    return old;
  endfunction

  function automatic lb_data_t expected_reg(input lb_addr_t a);
    case (a)
      `GPU_CONTROL_ADDR:    return lb_data_t'(enable);
      `GPU_STATUS_ADDR:     return '0;
      `GPU_JOB_ACTION_ADDR: return lb_data_t'(action);
      `GPU_JOB_X0_ADDR:     return lb_data_t'(job_x0);
      `GPU_JOB_Y0_ADDR:     return lb_data_t'(job_y0);
      `GPU_JOB_X1_ADDR:     return lb_data_t'(job_x1);
      `GPU_JOB_Y1_ADDR:     return lb_data_t'(job_y1);
      `GPU_JOB_COLOR_ADDR:  return lb_data_t'(job_color);
      `GPU_PXL_ADDR_ADDR:   return lb_data_t'(pxl_addr);
      default:              return `GPU_BAD_ADDR_DATA;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic reset_state();
    enable      = 1'b0;
    action      = DRAW;
    job_x0      = '0;
    job_y0      = '0;
    job_x1      = '0;
    job_y1      = '0;
    job_color   = '0;
    pxl_addr    = '0;
    job_running = 1'b0;
    launch_age  = 0;
    wr_expect   = 1'b0;
    rd_expect   = 1'b0;
    status_any  = 1'b0;
    pxl_wait    = 1'b0;
    pxl_cycles  = 0;
    exp_addr    = '0;
    exp_data    = '0;
    error_count = 0;
    check_count = 0;
    // Frame memory clears at reset
    for (int i = 0; i < FRAME_PIXELS; i++)
      model[i] = '0;
  endtask

  task automatic apply_job();
    for (int i = 0; i < FRAME_PIXELS; i++)
      model[i] = expected_pixel(action, job_x0, job_y0, job_x1, job_y1, job_color, i, model[i]);
  endtask

  task automatic apply_write();
    case (addr)
      `GPU_CONTROL_ADDR:    enable = wr_data[0];
      `GPU_JOB_ACTION_ADDR:
      begin
        action = action_t'(wr_data[1:0]);
        // Launch only with enable already set
        if (enable)
        begin
          apply_job();
          job_running = 1'b1;
          launch_age  = 0;
        end
      end
      `GPU_JOB_X0_ADDR:     job_x0 = wr_data[`GPU_COORD_W-1:0];
      `GPU_JOB_Y0_ADDR:     job_y0 = wr_data[`GPU_COORD_W-1:0];
      `GPU_JOB_X1_ADDR:     job_x1 = wr_data[`GPU_COORD_W-1:0];
      `GPU_JOB_Y1_ADDR:     job_y1 = wr_data[`GPU_COORD_W-1:0];
      `GPU_JOB_COLOR_ADDR:  job_color = wr_data[`GPU_COLOR_W-1:0];
      `GPU_PXL_ADDR_ADDR:   pxl_addr = wr_data[`GPU_FB_ADDR_W-1:0];
      default:              ;
    endcase
  endtask

  task automatic compare_read();
    check_count++;
    if (status_any)
    begin
      // Job may still be running, 0 or 1 both legal
      if (rd_data[31:1] != '0)
      begin
        $display("CHECK FAILED rd_data addr 0x%02h expected 0x00000000 or 0x00000001 actual 0x%08h",
                 exp_addr, rd_data);
        error_count++;
      end
      else if (!rd_data[0])
        job_running = 1'b0;
    end
    else if (rd_data !== exp_data)
    begin
      $display("CHECK FAILED rd_data addr 0x%02h expected 0x%08h actual 0x%08h",
               exp_addr, exp_data, rd_data);
      error_count++;
    end
  endtask

  task automatic check_responses();
    // wr_valid exactly one cycle after the write strobe
    if (wr_expect && !wr_valid)
      report_error("wr_valid did not follow a write strobe by one cycle");
    else if (!wr_expect && wr_valid)
      report_error("wr_valid rose without a write strobe");

    if (rd_expect)
    begin
      if (!rd_valid)
        report_error("rd_valid did not follow a register read by one cycle");
      else
        compare_read();
    end
    else if (pxl_wait)
    begin
      if (rd_valid)
      begin
        compare_read();
        pxl_wait = 1'b0;
      end
      else
      begin
        pxl_cycles++;
        if (pxl_cycles > PXL_WAIT_LIMIT)
        begin
          report_error("rd_valid never arrived for a PXL_DATA read");
          pxl_wait = 1'b0;
        end
      end
    end
    else if (rd_valid)
      report_error("rd_valid rose without a pending read");
  endtask

  task automatic sample_strobes();
    wr_expect = wr_en;
    rd_expect = 1'b0;
    if (wr_en)
      apply_write();
    if (rd_en)
    begin
      exp_addr   = addr;
      status_any = 1'b0;
      if (addr == `GPU_PXL_DATA_ADDR)
      begin
        pxl_wait   = 1'b1;
        pxl_cycles = 0;
        exp_data   = lb_data_t'(model[pxl_addr]);
      end
      else
      begin
        rd_expect = 1'b1;
        exp_data  = expected_reg(addr);
        if ((addr == `GPU_STATUS_ADDR) && job_running)
        begin
          // Engine is certainly busy just after the launch
          if (launch_age >= BUSY_FIRST_AGE && launch_age <= BUSY_LAST_AGE)
            exp_data = lb_data_t'(1);
          else
            status_any = 1'b1;
        end
      end
    end
  endtask

  // Inputs change on the falling edge, outputs settle after the rising one
  always @(posedge cr_intf)
  begin
    if (!rst_n)
      reset_state();
    else
    begin
      launch_age++;
      check_responses();
      sample_strobes();
    end
  end

endmodule

// ==== dv/tb_gpu_core.sv ====
//****************************************
// Host stimulus for the drawing core, inputs change on falling edges
// Pixel reads only once STATUS shows the engine idle
//****************************************
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module tb_gpu_core;

  import gpu_pkg::*;

  // 8 jobs of 256 pixels at 3 cycles, five full readbacks, plus margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RESET_CYCLES = 16;
  // job_start one cycle after the write, busy one cycle later
  localparam int JOB_LAUNCH_CYCLES = 2;
  localparam int WR_WAIT_LIMIT = 8;
  localparam int RD_WAIT_LIMIT = 1200;

  logic        cr_intf;
  logic        rst_n;
  lb_addr_t    addr;
  logic        wr_en;
  lb_data_t    wr_data;
  logic        rd_en;
  logic        wr_valid;
  logic        rd_valid;
  lb_data_t    rd_data;
  int          error_count;
  int          check_count;
  int          cycles = 0;
  logic [31:0] lcg_state;

  gpu_core gpu_core_inst
  (
    .cr_intf  (cr_intf),
    .rst_n    (rst_n),
    .addr     (addr),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .wr_valid (wr_valid),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  gpu_checker gpu_checker_inst
  (
    .cr_intf     (cr_intf),
    .rst_n       (rst_n),
    .addr        (addr),
    .wr_en       (wr_en),
    .wr_data     (wr_data),
    .rd_en       (rd_en),
    .wr_valid    (wr_valid),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial
  begin
    cr_intf = 1'b0;
    forever #2 cr_intf = ~cr_intf;
  end

  // Run limit
  always @(posedge cr_intf)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // All host tasks start and end just after a falling edge
  task automatic write_reg(input lb_addr_t a, input lb_data_t d);
    int n;
    addr    = a;
    wr_data = d;
    wr_en   = 1'b1;
    @(negedge cr_intf);
    wr_en = 1'b0;
    n = 0;
    while (!wr_valid && n < WR_WAIT_LIMIT)
    begin
      @(negedge cr_intf);
      n++;
    end
  endtask

  task automatic read_reg(input lb_addr_t a, output lb_data_t d);
    int n;
    addr  = a;
    rd_en = 1'b1;
    @(negedge cr_intf);
    rd_en = 1'b0;
    n = 0;
    // PXL_DATA waits on the memory bus
    while (!rd_valid && n < RD_WAIT_LIMIT)
    begin
      @(negedge cr_intf);
      n++;
    end
    d = rd_data;
  endtask

  task automatic wait_idle();
    lb_data_t s;
    read_reg(`GPU_STATUS_ADDR, s);
    while (s[0])
      read_reg(`GPU_STATUS_ADDR, s);
  endtask

  task automatic run_job
  (
    input action_t act,
    input coord_t  ax,
    input coord_t  ay,
    input coord_t  bx,
    input coord_t  by,
    input color_t  c
  );
    write_reg(`GPU_JOB_X0_ADDR, lb_data_t'(ax));
    write_reg(`GPU_JOB_Y0_ADDR, lb_data_t'(ay));
    write_reg(`GPU_JOB_X1_ADDR, lb_data_t'(bx));
    write_reg(`GPU_JOB_Y1_ADDR, lb_data_t'(by));
    write_reg(`GPU_JOB_COLOR_ADDR, lb_data_t'(c));
    write_reg(`GPU_JOB_ACTION_ADDR, lb_data_t'(act));
    repeat (JOB_LAUNCH_CYCLES) @(negedge cr_intf);
    wait_idle();
  endtask

  // Every pixel goes through the checker
  task automatic readback_frame();
    lb_data_t d;
    for (int i = 0; i < `GPU_FRAME_W * `GPU_FRAME_H; i++)
    begin
      write_reg(`GPU_PXL_ADDR_ADDR, lb_data_t'(i));
      read_reg(`GPU_PXL_DATA_ADDR, d);
    end
  endtask

  task automatic draw_random();
    logic [31:0] r;
    logic [31:0] c;
    r = next_rand();
    c = next_rand();
    run_job(DRAW, r[19:16], r[23:20], r[27:24], r[31:28], c[23:16]);
  endtask

  initial
  begin
    lb_data_t    d;
    logic [31:0] r;
    logic [31:0] c;
    coord_t      xa;
    coord_t      xb;
    coord_t      ya;
    coord_t      yb;

    rst_n     = 1'b0;
    addr      = '0;
    wr_en     = 1'b0;
    wr_data   = '0;
    rd_en     = 1'b0;
    lcg_state = 32'hd5e5;
    repeat (RESET_CYCLES) @(negedge cr_intf);
    rst_n = 1'b1;
    @(negedge cr_intf);

    // Register readback, enable still off so no launch
    write_reg(`GPU_JOB_X0_ADDR, 32'h3);
    write_reg(`GPU_JOB_Y0_ADDR, 32'h5);
    write_reg(`GPU_JOB_X1_ADDR, 32'ha);
    write_reg(`GPU_JOB_Y1_ADDR, 32'hc);
    write_reg(`GPU_JOB_COLOR_ADDR, 32'h5a);
    write_reg(`GPU_PXL_ADDR_ADDR, 32'h37);
    write_reg(`GPU_JOB_ACTION_ADDR, 32'h1);
    for (int a = 0; a <= 32'h20; a += 4)
      read_reg(lb_addr_t'(a), d);

    // Unmapped and misaligned addresses
    read_reg(8'h28, d);
    read_reg(8'h03, d);
    read_reg(8'hfc, d);

    write_reg(`GPU_CONTROL_ADDR, 32'h1);
    read_reg(`GPU_CONTROL_ADDR, d);

    // Random rectangle
    draw_random();
    readback_frame();

    // Same area with the corners given both ways
    r  = next_rand();
    c  = next_rand();
    xa = (r[19:16] < r[27:24]) ? r[19:16] : r[27:24];
    xb = (r[19:16] < r[27:24]) ? r[27:24] : r[19:16];
    ya = (r[23:20] < r[31:28]) ? r[23:20] : r[31:28];
    yb = (r[23:20] < r[31:28]) ? r[31:28] : r[23:20];
    run_job(DRAW, xa, ya, xb, yb, c[23:16]);
    run_job(DRAW, xb, yb, xa, ya, ~c[23:16]);
    readback_frame();

    // Full frame fill
    c = next_rand();
    run_job(CLEAR, 4'h7, 4'h2, 4'h1, 4'h9, c[23:16]);
    readback_frame();

    // Enable off, frame must stay as it is
    write_reg(`GPU_CONTROL_ADDR, 32'h0);
    run_job(CLEAR, 4'h0, 4'h0, 4'hf, 4'hf, 8'hc3);
    read_reg(`GPU_STATUS_ADDR, d);
    readback_frame();

    // A few more on top of the fill
    write_reg(`GPU_CONTROL_ADDR, 32'h1);
    repeat (3) draw_random();
    readback_frame();

    repeat (2) @(negedge cr_intf);
    $display("Errors: %0d, read checks: %0d", error_count, check_count);
    if (check_count == 0)
      $display("No read responses were checked");
    if (error_count == 0 && check_count > 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+source
source/gpu_pkg.sv
source/gpu_regs.sv
source/gpu_rect_engine.sv
source/gpu_bus_arbiter.sv
source/gpu_frame_mem.sv
source/gpu_core.sv
dv/gpu_checker.sv
dv/tb_gpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the drawing core testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_gpu_core \
  -Mdir obj_dir -o sim_gpu_core > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_gpu_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
